// File: verilog/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // byte address and data word sizes seen by the requester
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // 1 KB direct-mapped geometry
    localparam int LINE_BYTES = 32;
    localparam int SET_COUNT  = 32;

    localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int WORD_SEL_WIDTH = $clog2(LINE_BYTES / (WORD_WIDTH / 8));
    localparam int INDEX_WIDTH    = $clog2(SET_COUNT);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH     = LINE_BYTES * 8;

    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;

    // one address word, read either as a flat byte address or split into fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            tag_t                                   tag;
            index_t                                 index;
            logic [WORD_SEL_WIDTH-1:0]              word_sel;
            logic [OFFSET_WIDTH-WORD_SEL_WIDTH-1:0] byte_sel;
        } fields;
    } cache_addr_t;

endpackage

// File: verilog/cache_if_pkg.sv
package cache_if_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // word request from the single requester
    typedef struct packed {
        cache_op_e                             op;
        logic [cache_cfg_pkg::ADDR_WIDTH-1:0]  addr;
        cache_cfg_pkg::word_t                  wdata;
    } cache_req_t;

    // read data is zero on a write response
    typedef struct packed {
        cache_op_e            op;
        logic                 hit;
        cache_cfg_pkg::word_t rdata;
    } cache_rsp_t;

    typedef struct packed {
        cache_cfg_pkg::index_t index;
        logic                  valid;
        logic                  dirty;
        cache_cfg_pkg::tag_t   tag;
        cache_cfg_pkg::line_t  line;
    } array_wr_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        cache_cfg_pkg::tag_t  tag;
        cache_cfg_pkg::line_t line;
    } array_rd_t;

    // line-aligned address plus line, the line is unused on fill requests
    typedef struct packed {
        logic [cache_cfg_pkg::ADDR_WIDTH-1:0] addr;
        cache_cfg_pkg::line_t                 line;
    } mem_req_t;

endpackage

// File: verilog/cache_ram_sdp.sv
`timescale 1ns/1ps

// simple dual-port RAM, one write port and one registered read port
module cache_ram_sdp #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 32
) (
    input  logic                     clk,

    input  logic                     i_re,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output logic [DATA_WIDTH-1:0]    o_rdata,

    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  logic [DATA_WIDTH-1:0]    i_wdata
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // a read of the address being written returns the old contents
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// File: verilog/cache_array.sv
`timescale 1ns/1ps

module cache_array (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_rd_en,
    input  cache_cfg_pkg::index_t   i_rd_index,

    input  logic                    i_wr_en,
    input  cache_if_pkg::array_wr_t i_wr,

    output cache_if_pkg::array_rd_t o_rd
);

    logic [cache_cfg_pkg::SET_COUNT-1:0] valid_q;
    logic [cache_cfg_pkg::SET_COUNT-1:0] dirty_q;

    logic                 wr_bypass;
    logic                 rd_valid;
    logic                 rd_dirty;
    logic                 rd_valid_q;
    logic                 rd_dirty_q;
    cache_cfg_pkg::tag_t  rd_tag;
    cache_cfg_pkg::line_t rd_line;

    // every set starts out invalid and clean after reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr.index] <= i_wr.valid;
            dirty_q[i_wr.index] <= i_wr.dirty;
        end
    end

    // a write to the set being read wins over the stored bits
    assign wr_bypass = i_wr_en && (i_wr.index == i_rd_index);
    assign rd_valid  = wr_bypass ? i_wr.valid : valid_q[i_rd_index];
    assign rd_dirty  = wr_bypass ? i_wr.dirty : dirty_q[i_rd_index];

    // state is registered on a read only, so it lines up with the RAM outputs
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else if (i_rd_en) begin
            rd_valid_q <= rd_valid;
            rd_dirty_q <= rd_dirty;
        end
    end

    cache_ram_sdp #(
        .DATA_WIDTH (cache_cfg_pkg::TAG_WIDTH),
        .DEPTH      (cache_cfg_pkg::SET_COUNT)
    ) u_tag_ram (
        .clk     (clk),
        .i_re    (i_rd_en),
        .i_raddr (i_rd_index),
        .o_rdata (rd_tag),
        .i_we    (i_wr_en),
        .i_waddr (i_wr.index),
        .i_wdata (i_wr.tag)
    );

    cache_ram_sdp #(
        .DATA_WIDTH (cache_cfg_pkg::LINE_WIDTH),
        .DEPTH      (cache_cfg_pkg::SET_COUNT)
    ) u_line_ram (
        .clk     (clk),
        .i_re    (i_rd_en),
        .i_raddr (i_rd_index),
        .o_rdata (rd_line),
        .i_we    (i_wr_en),
        .i_waddr (i_wr.index),
        .i_wdata (i_wr.line)
    );

    always_comb begin
        o_rd.valid = rd_valid_q;
        o_rd.dirty = rd_dirty_q;
        o_rd.tag   = rd_tag;
        o_rd.line  = rd_line;
    end

endmodule

// File: verilog/cache_decode.sv
`timescale 1ns/1ps

module cache_decode (
    input  logic                       clk,
    input  logic                       i_rst_n,

    input  logic                       i_req_valid,
    input  cache_if_pkg::cache_req_t   i_req,
    input  logic                       i_busy,

    output cache_if_pkg::cache_req_t   o_req,
    output cache_cfg_pkg::cache_addr_t o_addr,
    output logic                       o_req_valid,

    output logic                       o_rd_en,
    output cache_cfg_pkg::index_t      o_rd_index
);

    logic                       accept;
    logic                       req_valid_q;
    cache_if_pkg::cache_req_t   req_q;
    cache_cfg_pkg::cache_addr_t in_addr;

    // a strobe that arrives while busy is dropped
    assign accept = i_req_valid && !i_busy;

    always_comb begin
        in_addr.flat = i_req.addr;
    end

    // the arrays are read in the acceptance cycle so their output meets the held request
    assign o_rd_en    = accept;
    assign o_rd_index = in_addr.fields.index;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_req;
        end
    end

    assign o_req       = req_q;
    assign o_req_valid = req_valid_q;

    always_comb begin
        o_addr.flat = req_q.addr;
    end

endmodule

// File: verilog/cache_execute.sv
`timescale 1ns/1ps

module cache_execute (
    input  logic                       clk,
    input  logic                       i_rst_n,

    input  logic                       i_req_valid,
    input  cache_if_pkg::cache_req_t   i_req,
    input  cache_cfg_pkg::cache_addr_t i_addr,
    input  cache_if_pkg::array_rd_t    i_array,

    input  logic                       i_mem_rd_ack,
    input  cache_cfg_pkg::line_t       i_mem_rd_line,
    input  logic                       i_mem_wr_ack,

    output logic                       o_busy,
    output logic                       o_mem_rd_req,
    output cache_if_pkg::mem_req_t     o_mem_rd,
    output logic                       o_mem_wr_req,
    output cache_if_pkg::mem_req_t     o_mem_wr,

    output logic                       o_commit,
    output cache_cfg_pkg::line_t       o_commit_line,
    output cache_cfg_pkg::tag_t        o_commit_tag,
    output logic                       o_commit_hit
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL,
        ST_COMMIT
    } state_e;

    state_e state_q;
    state_e state;
    state_e state_next;

    logic                       hit;
    logic                       victim_dirty;
    logic                       mem_rd_req_q;
    logic                       mem_wr_req_q;
    logic                       rsp_pending_q;
    cache_cfg_pkg::line_t       fill_line_q;
    cache_cfg_pkg::cache_addr_t fill_addr;
    cache_cfg_pkg::cache_addr_t victim_addr;

    // the request from decode is compared in the same cycle it shows up
    assign state = (state_q == ST_IDLE && i_req_valid) ? ST_COMPARE : state_q;

    assign hit          = i_array.valid && (i_array.tag == i_addr.fields.tag);
    assign victim_dirty = i_array.valid && i_array.dirty;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                state_next = ST_IDLE;
            end
            ST_COMPARE: begin
                if (hit) begin
                    state_next = ST_IDLE;
                end else if (victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_FILL;
                end
            end
            ST_WRITEBACK: begin
                if (i_mem_wr_ack) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (i_mem_rd_ack) begin
                    state_next = ST_COMMIT;
                end
            end
            ST_COMMIT: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // memory strobes are registered, so each is a single pulse on the cycle a wait state opens
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q       <= ST_IDLE;
            mem_wr_req_q  <= 1'b0;
            mem_rd_req_q  <= 1'b0;
            rsp_pending_q <= 1'b0;
        end else begin
            state_q       <= state_next;
            mem_wr_req_q  <= (state == ST_COMPARE) && !hit && victim_dirty;
            mem_rd_req_q  <= ((state == ST_COMPARE) && !hit && !victim_dirty) ||
                             ((state == ST_WRITEBACK) && i_mem_wr_ack);
            rsp_pending_q <= o_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FILL && i_mem_rd_ack) begin
            fill_line_q <= i_mem_rd_line;
        end
    end

    // line addresses are rebuilt from the request with the offset bits cleared
    always_comb begin
        fill_addr                 = '0;
        fill_addr.flat            = i_req.addr;
        fill_addr.fields.word_sel = '0;
        fill_addr.fields.byte_sel = '0;
    end

    // the victim sits in the same set, only its tag differs
    always_comb begin
        victim_addr            = fill_addr;
        victim_addr.fields.tag = i_array.tag;
    end

    assign o_mem_wr_req  = mem_wr_req_q;
    assign o_mem_wr.addr = victim_addr.flat;
    assign o_mem_wr.line = i_array.line;

    assign o_mem_rd_req  = mem_rd_req_q;
    assign o_mem_rd.addr = fill_addr.flat;
    assign o_mem_rd.line = '0;

    // busy also covers the cycle in which result presents the response
    assign o_busy = (state != ST_IDLE) || rsp_pending_q;

    assign o_commit      = ((state == ST_COMPARE) && hit) || (state == ST_COMMIT);
    assign o_commit_line = (state == ST_COMMIT) ? fill_line_q : i_array.line;
    assign o_commit_tag  = i_addr.fields.tag;
    assign o_commit_hit  = (state == ST_COMPARE);

endmodule

// File: verilog/cache_result.sv
`timescale 1ns/1ps

module cache_result (
    input  logic                       clk,
    input  logic                       i_rst_n,

    input  logic                       i_commit,
    input  cache_if_pkg::cache_req_t   i_req,
    input  cache_cfg_pkg::cache_addr_t i_addr,
    input  cache_cfg_pkg::line_t       i_line,
    input  cache_cfg_pkg::tag_t        i_tag,
    input  logic                       i_hit,

    output logic                       o_array_wr_en,
    output cache_if_pkg::array_wr_t    o_array_wr,

    output logic                       o_rsp_valid,
    output cache_if_pkg::cache_rsp_t   o_rsp
);

    logic                     is_write;
    logic                     rsp_valid_q;
    cache_cfg_pkg::word_t     rd_word;
    cache_cfg_pkg::line_t     merged_line;
    cache_if_pkg::cache_rsp_t rsp_q;

    assign is_write = (i_req.op == cache_if_pkg::OP_WRITE);

    assign rd_word = i_line[i_addr.fields.word_sel * cache_cfg_pkg::WORD_WIDTH +:
                            cache_cfg_pkg::WORD_WIDTH];

    always_comb begin
        merged_line = i_line;
        if (is_write) begin
            merged_line[i_addr.fields.word_sel * cache_cfg_pkg::WORD_WIDTH +:
                        cache_cfg_pkg::WORD_WIDTH] = i_req.wdata;
        end
    end

    // a read hit leaves the set as it is, which keeps its dirty bit
    assign o_array_wr_en = i_commit && !(i_hit && !is_write);

    always_comb begin
        o_array_wr.index = i_addr.fields.index;
        o_array_wr.valid = 1'b1;
        o_array_wr.dirty = is_write;
        o_array_wr.tag   = i_tag;
        o_array_wr.line  = merged_line;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= i_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (i_commit) begin
            rsp_q.op    <= i_req.op;
            rsp_q.hit   <= i_hit;
            rsp_q.rdata <= is_write ? '0 : rd_word;
        end
    end

    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp       = rsp_q;

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  logic                     i_req_valid,
    input  cache_if_pkg::cache_req_t i_req,
    output logic                     o_busy,
    output logic                     o_rsp_valid,
    output cache_if_pkg::cache_rsp_t o_rsp,

    output logic                     o_mem_rd_req,
    output cache_if_pkg::mem_req_t   o_mem_rd,
    input  logic                     i_mem_rd_ack,
    input  cache_cfg_pkg::line_t     i_mem_rd_line,
    output logic                     o_mem_wr_req,
    output cache_if_pkg::mem_req_t   o_mem_wr,
    input  logic                     i_mem_wr_ack
);

    cache_if_pkg::cache_req_t   dec_req;
    cache_cfg_pkg::cache_addr_t dec_addr;
    logic                       dec_req_valid;
    logic                       rd_en;
    cache_cfg_pkg::index_t      rd_index;
    cache_if_pkg::array_rd_t    array_rd;
    logic                       array_wr_en;
    cache_if_pkg::array_wr_t    array_wr;
    logic                       commit;
    cache_cfg_pkg::line_t       commit_line;
    cache_cfg_pkg::tag_t        commit_tag;
    logic                       commit_hit;

    cache_decode u_decode (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_busy      (o_busy),
        .o_req       (dec_req),
        .o_addr      (dec_addr),
        .o_req_valid (dec_req_valid),
        .o_rd_en     (rd_en),
        .o_rd_index  (rd_index)
    );

    cache_array u_array (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd_en    (rd_en),
        .i_rd_index (rd_index),
        .i_wr_en    (array_wr_en),
        .i_wr       (array_wr),
        .o_rd       (array_rd)
    );

    cache_execute u_execute (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (dec_req_valid),
        .i_req         (dec_req),
        .i_addr        (dec_addr),
        .i_array       (array_rd),
        .i_mem_rd_ack  (i_mem_rd_ack),
        .i_mem_rd_line (i_mem_rd_line),
        .i_mem_wr_ack  (i_mem_wr_ack),
        .o_busy        (o_busy),
        .o_mem_rd_req  (o_mem_rd_req),
        .o_mem_rd      (o_mem_rd),
        .o_mem_wr_req  (o_mem_wr_req),
        .o_mem_wr      (o_mem_wr),
        .o_commit      (commit),
        .o_commit_line (commit_line),
        .o_commit_tag  (commit_tag),
        .o_commit_hit  (commit_hit)
    );

    cache_result u_result (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_commit      (commit),
        .i_req         (dec_req),
        .i_addr        (dec_addr),
        .i_line        (commit_line),
        .i_tag         (commit_tag),
        .i_hit         (commit_hit),
        .o_array_wr_en (array_wr_en),
        .o_array_wr    (array_wr),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp         (o_rsp)
    );

endmodule

// File: tb/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// 4 KB window behind the cache, so four tags compete for every set
localparam logic [31:0] WIN_BASE = 32'h0004_7000;

logic [15:0] lfsr_state = 16'd55580;

// golden memory for the window, one entry per word
cache_cfg_pkg::word_t gold_mem [1024];

// shadow copy of the cache contents
logic                 m_valid [cache_cfg_pkg::SET_COUNT];
logic                 m_dirty [cache_cfg_pkg::SET_COUNT];
cache_cfg_pkg::tag_t  m_tag   [cache_cfg_pkg::SET_COUNT];
cache_cfg_pkg::line_t m_line  [cache_cfg_pkg::SET_COUNT];

// fibonacci taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsr_bit()};
    end
    return value;
endfunction

// every word starts with a value built from its full byte address
function automatic cache_cfg_pkg::word_t mem_pattern(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
endfunction

function automatic void model_reset();
    for (int i = 0; i < 1024; i++) begin
        gold_mem[i] = mem_pattern(WIN_BASE | (32'(i) << 2));
    end
    for (int s = 0; s < cache_cfg_pkg::SET_COUNT; s++) begin
        m_valid[s] = 1'b0;
        m_dirty[s] = 1'b0;
        m_tag[s]   = '0;
        m_line[s]  = '0;
    end
endfunction

function automatic cache_cfg_pkg::line_t gold_line(input logic [31:0] addr);
    cache_cfg_pkg::line_t line;
    logic [9:0]           idx;
    line = '0;
    for (int w = 0; w < 8; w++) begin
        idx = {addr[11:5], w[2:0]};
        line[w*32 +: 32] = gold_mem[idx];
    end
    return line;
endfunction

function automatic void gold_store_line(input logic [31:0] addr,
                                        input cache_cfg_pkg::line_t line);
    logic [9:0] idx;
    for (int w = 0; w < 8; w++) begin
        idx = {addr[11:5], w[2:0]};
        gold_mem[idx] = line[w*32 +: 32];
    end
endfunction

// set is address bits 9:5 and tag is bits 31:10
function automatic logic model_hit(input logic [31:0] addr);
    return m_valid[addr[9:5]] && (m_tag[addr[9:5]] == addr[31:10]);
endfunction

// applies one access to the shadow state and returns the response it expects
function automatic cache_if_pkg::cache_rsp_t model_access(input cache_if_pkg::cache_op_e op,
                                                          input logic [31:0] addr,
                                                          input cache_cfg_pkg::word_t wdata);
    cache_if_pkg::cache_rsp_t rsp;
    cache_cfg_pkg::index_t    set;
    cache_cfg_pkg::line_t     line;
    int                       base;
    set  = addr[9:5];
    base = int'(addr[4:2]) * 32;
    rsp.op  = op;
    rsp.hit = model_hit(addr);
    if (!rsp.hit) begin
        m_line[set]  = gold_line(addr);
        m_tag[set]   = addr[31:10];
        m_valid[set] = 1'b1;
        m_dirty[set] = 1'b0;
    end
    line = m_line[set];
    if (op == cache_if_pkg::OP_WRITE) begin
        line[base +: 32] = wdata;
        m_line[set]      = line;
        m_dirty[set]     = 1'b1;
        rsp.rdata        = '0;
    end else begin
        rsp.rdata = line[base +: 32];
    end
    return rsp;
endfunction

`endif

// File: tb/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    localparam int REQ_COUNT    = 400;
    localparam int REQ_TIMEOUT  = 100;
    localparam int IDLE_TIMEOUT = 50;

    logic                     clk = 1'b0;
    logic                     i_rst_n;
    logic                     i_req_valid;
    cache_if_pkg::cache_req_t i_req;
    logic                     o_busy;
    logic                     o_rsp_valid;
    cache_if_pkg::cache_rsp_t o_rsp;
    logic                     o_mem_rd_req;
    cache_if_pkg::mem_req_t   o_mem_rd;
    logic                     i_mem_rd_ack;
    cache_cfg_pkg::line_t     i_mem_rd_line;
    logic                     o_mem_wr_req;
    cache_if_pkg::mem_req_t   o_mem_wr;
    logic                     i_mem_wr_ack;

    string test_name;

    `include "tb_cache_model.svh"

    cache_top UUT (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_busy        (o_busy),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp         (o_rsp),
        .o_mem_rd_req  (o_mem_rd_req),
        .o_mem_rd      (o_mem_rd),
        .i_mem_rd_ack  (i_mem_rd_ack),
        .i_mem_rd_line (i_mem_rd_line),
        .o_mem_wr_req  (o_mem_wr_req),
        .o_mem_wr      (o_mem_wr),
        .i_mem_wr_ack  (i_mem_wr_ack)
    );

    always #2 clk = ~clk;

    task automatic end_in_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        end_in_failure();
    endtask

    task automatic check_rsp(input string name, input cache_if_pkg::cache_rsp_t expected,
                             input cache_if_pkg::cache_rsp_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected op=%0d hit=%0d rdata=%08h actual op=%0d hit=%0d rdata=%08h",
                     name, expected.op, expected.hit, expected.rdata,
                     actual.op, actual.hit, actual.rdata);
            end_in_failure();
        end
    endtask

    task automatic check_line(input string name, input cache_cfg_pkg::line_t expected,
                              input cache_cfg_pkg::line_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected line %064h actual line %064h", name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [cache_cfg_pkg::ADDR_WIDTH-1:0] expected,
                              input logic [cache_cfg_pkg::ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected address %08h actual address %08h", name, expected, actual);
            end_in_failure();
        end
    endtask

    // no strobe may show up while the cache has nothing pending
    task automatic wait_not_busy();
        int   waited;
        logic idle;
        waited = 0;
        idle   = 1'b0;
        while (!idle) begin
            if (o_rsp_valid || o_mem_rd_req || o_mem_wr_req) begin
                report_error("a response or memory strobe appeared with no request open");
            end
            if (!o_busy) begin
                idle = 1'b1;
            end else if (waited >= IDLE_TIMEOUT) begin
                report_error("timed out waiting for o_busy to drop");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // runs one request from strobe to response and answers the memory side on the way
    task automatic run_request(input cache_if_pkg::cache_op_e op, input logic [31:0] addr,
                               input cache_cfg_pkg::word_t wdata);
        cache_cfg_pkg::index_t    set;
        logic                     exp_hit;
        logic                     exp_wb;
        logic                     got_rsp;
        logic                     seen_wr;
        logic                     seen_rd;
        logic                     wr_acked;
        logic                     rd_acked;
        int                       cycle;
        int                       wr_ack_at;
        int                       rd_ack_at;
        logic [31:0]              lat;
        cache_cfg_pkg::line_t     fill_line;
        cache_if_pkg::cache_rsp_t exp_rsp;
        set       = addr[9:5];
        exp_hit   = model_hit(addr);
        exp_wb    = !exp_hit && m_valid[set] && m_dirty[set];
        got_rsp   = 1'b0;
        seen_wr   = 1'b0;
        seen_rd   = 1'b0;
        wr_acked  = 1'b0;
        rd_acked  = 1'b0;
        wr_ack_at = -1;
        rd_ack_at = -1;
        fill_line = '0;
        wait_not_busy();
        i_req_valid = 1'b1;
        i_req.op    = op;
        i_req.addr  = addr;
        i_req.wdata = wdata;
        @(negedge clk);
        i_req_valid = 1'b0;
        cycle = 1;
        while (!got_rsp) begin
            if (cycle > REQ_TIMEOUT) begin
                report_error("timed out waiting for the response");
            end
            if (!o_busy) begin
                report_error("o_busy dropped while the request was still open");
            end
            if (o_mem_wr_req) begin
                if (!exp_wb || seen_wr || cycle != 2) begin
                    report_error("write-back request where none was expected");
                end
                check_addr(test_name, {m_tag[set], set, 5'b00000}, o_mem_wr.addr);
                check_line(test_name, m_line[set], o_mem_wr.line);
                gold_store_line(o_mem_wr.addr, o_mem_wr.line);
                seen_wr   = 1'b1;
                lat       = rand_bits(3);
                wr_ack_at = cycle + 1 + int'(lat[2:0]);
            end
            if (o_mem_rd_req) begin
                if (exp_hit || seen_rd) begin
                    report_error("fill request where none was expected");
                end
                if (exp_wb ? !wr_acked : (cycle != 2)) begin
                    report_error("fill request came out of order");
                end
                check_addr(test_name, {addr[31:5], 5'b00000}, o_mem_rd.addr);
                fill_line = gold_line(addr);
                seen_rd   = 1'b1;
                lat       = rand_bits(3);
                rd_ack_at = cycle + 1 + int'(lat[2:0]);
            end
            if (o_rsp_valid) begin
                if (exp_hit ? (cycle != 2) : (!rd_acked || cycle != rd_ack_at + 2)) begin
                    report_error("response came at the wrong time");
                end
                exp_rsp = model_access(op, addr, wdata);
                check_rsp(test_name, exp_rsp, o_rsp);
                got_rsp = 1'b1;
            end else if (exp_hit && cycle >= 2) begin
                report_error("no response two cycles after a hit");
            end
            // acknowledges are single-cycle pulses
            i_mem_wr_ack = (cycle == wr_ack_at);
            i_mem_rd_ack = (cycle == rd_ack_at);
            if (i_mem_wr_ack) begin
                wr_acked = 1'b1;
            end
            if (i_mem_rd_ack) begin
                rd_acked      = 1'b1;
                i_mem_rd_line = fill_line;
            end
            @(negedge clk);
            cycle++;
        end
        if (o_busy) begin
            report_error("o_busy stayed high after the response cycle");
        end
    endtask

    initial begin
        logic [31:0]             r;
        logic [31:0]             addr;
        cache_cfg_pkg::word_t    wdata;
        cache_if_pkg::cache_op_e op;
        i_rst_n       = 1'b0;
        i_req_valid   = 1'b0;
        i_req         = '0;
        i_mem_rd_ack  = 1'b0;
        i_mem_rd_line = '0;
        i_mem_wr_ack  = 1'b0;
        test_name     = "reset";
        model_reset();
        repeat (16) @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        if ({o_busy, o_rsp_valid, o_mem_rd_req, o_mem_wr_req} !== 4'b0000) begin
            report_error("outputs are not idle after reset");
        end

        // 0x104 and 0x504 share set 8 with different tags
        test_name = "write miss then read hit";
        run_request(cache_if_pkg::OP_WRITE, WIN_BASE | 32'h104, 32'hCAFE_0001);
        run_request(cache_if_pkg::OP_READ, WIN_BASE | 32'h104, '0);
        test_name = "dirty eviction";
        run_request(cache_if_pkg::OP_WRITE, WIN_BASE | 32'h504, 32'h1234_5678);
        test_name = "refill of evicted write";
        run_request(cache_if_pkg::OP_READ, WIN_BASE | 32'h104, '0);

        for (int n = 0; n < REQ_COUNT; n++) begin
            r     = rand_bits(1);
            op    = r[0] ? cache_if_pkg::OP_WRITE : cache_if_pkg::OP_READ;
            r     = rand_bits(10);
            addr  = WIN_BASE | {20'h0_0000, r[9:0], 2'b00};
            wdata = rand_bits(32);
            test_name = $sformatf("random %0d %s 0x%08h", n, op.name(), addr);
            run_request(op, addr, wdata);
            r = rand_bits(2);
            // the idle gap between requests is watched for stray strobes too
            repeat (int'(r[1:0])) begin
                wait_not_busy();
                @(negedge clk);
            end
        end

        wait_not_busy();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+tb
verilog/cache_cfg_pkg.sv
verilog/cache_if_pkg.sv
verilog/cache_ram_sdp.sv
verilog/cache_array.sv
verilog/cache_decode.sv
verilog/cache_execute.sv
verilog/cache_result.sv
verilog/cache_top.sv
tb/tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cache
FILELIST  := src.f
VFLAGS    := --binary --timing --top-module $(TOP)

SIM_BIN   := obj_dir/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf obj_dir
